// File: verilog/serial_pkg.sv
/*
 * shared constants of the serial link
 *  - word width and bit order on the data line
 *  - idle levels of the serial clock and data lines
 *  - serial clock divider
 *  - queue depth, frame length and latch pulse width
 *  - derived counter widths
 */

package serial_pkg;

	// parallel word
	localparam int WORD_BITS = 8;
	// 1: bit 0 leaves first
	localparam bit LOWBIT_FIRST = 1'b1;

	// line levels while nothing is sent
	localparam logic SERIAL_CLK_INACTIVE = 1'b1;
	localparam logic SERIAL_DATA_INACTIVE = 1'b1;

	// main clock / (2 * serial clock)
	localparam int CLK_DIV_HALF = 4;

	// words held in front of the serialiser
	localparam int QUEUE_DEPTH = 4;

	// words per latched frame and latch width in main clock cycles
	localparam int FRAME_WORDS = 2;
	localparam int LATCH_CYCLES = 4;

	// counter widths
	localparam int BIT_CTR_BITS = $clog2(WORD_BITS);
	localparam int CLK_DIV_BITS = $clog2(CLK_DIV_HALF + 1);
	localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_BITS = $clog2(QUEUE_DEPTH + 1);
	localparam int FRAME_CTR_BITS = $clog2(FRAME_WORDS + 1);
	localparam int LATCH_CTR_BITS = $clog2(LATCH_CYCLES + 1);

endpackage

// File: verilog/word_queue.sv
/*
 * input queue of parallel words
 *  - circular buffer with read and write pointers
 *  - occupancy count drives head valid and full
 *  - writes while full are dropped
 */

module word_queue import serial_pkg::*; (
	input  logic                 in_clk,
	input  logic                 in_rst,

	// host side
	input  logic [WORD_BITS-1:0] in_word,
	input  logic                 in_write,
	output logic                 full,

	// serialiser side
	input  logic                 pop,
	output logic [WORD_BITS-1:0] head_word,
	output logic                 head_valid
);

	// storage, no reset needed
	logic [WORD_BITS-1:0] mem [QUEUE_DEPTH];

	logic [QUEUE_PTR_BITS-1:0] wr_ptr;
	logic [QUEUE_PTR_BITS-1:0] rd_ptr;
	logic [QUEUE_CNT_BITS-1:0] count;

	// accepted strobes
	logic do_write;
	logic do_read;

	assign full = (count == QUEUE_CNT_BITS'(QUEUE_DEPTH));
	assign head_valid = (count != '0);
	assign head_word = mem[rd_ptr];

	// a write into a full queue is lost
	assign do_write = in_write && !full;
	// pop only counts with a word present
	assign do_read = pop && head_valid;

	// word store
	always_ff @(posedge in_clk) begin
		if (do_write) begin
			mem[wr_ptr] <= in_word;
		end
	end

	// pointers, wrapping at the depth
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				if (wr_ptr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				if (rd_ptr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// occupancy
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			count <= '0;
		end else begin
			// write and pop together keep the count
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

endmodule

// File: verilog/serial_clock_gen.sv
/*
 * free-running serial clock divider
 *  - toggles sclk every CLK_DIV_HALF main clock cycles
 *  - fall tick marks the edge away from the idle level
 */

module serial_clock_gen import serial_pkg::*; (
	input  logic in_clk,
	input  logic in_rst,

	output logic sclk,
	output logic fall_tick
);

	// half period counter
	logic [CLK_DIV_BITS-1:0] div_ctr;
	logic                    wrap;

	assign wrap = (div_ctr == CLK_DIV_BITS'(CLK_DIV_HALF - 1));

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			div_ctr <= '0;
			sclk <= SERIAL_CLK_INACTIVE;
			fall_tick <= 1'b0;
		end else begin
			// tick is high in the same cycle as the new level
			fall_tick <= wrap && (sclk == SERIAL_CLK_INACTIVE);

			if (wrap) begin
				div_ctr <= '0;
				sclk <= ~sclk;
			end else begin
				div_ctr <= div_ctr + 1'b1;
			end
		end
	end

endmodule

// File: verilog/word_serializer.sv
/*
 * word serialiser
 *  - FSM idle / loaded / shifting
 *  - pops words from the queue, shifts them on fall ticks
 *  - back-to-back words without a gap while the queue has data
 *  - gated outgoing serial clock, word done pulse
 */

module word_serializer import serial_pkg::*; (
	input  logic                 in_clk,
	input  logic                 in_rst,

	// queue head
	input  logic [WORD_BITS-1:0] head_word,
	input  logic                 head_valid,
	output logic                 pop,

	// divided clock
	input  logic                 sclk,
	input  logic                 fall_tick,

	// status
	output logic                 word_done,
	output logic                 busy,

	// serial line
	output logic                 out_clk,
	output logic                 out_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOADED,
		ST_SHIFT
	} state_t;

	state_t state;
	state_t state_next;

	// word being sent, payload only
	logic [WORD_BITS-1:0] word_reg;
	// word whose first bit goes out next
	logic [WORD_BITS-1:0] start_word;

	logic [BIT_CTR_BITS-1:0] bit_ctr;
	logic [BIT_CTR_BITS-1:0] bit_next;
	logic                    last_bit;

	// bit at position idx in line order
	function automatic logic pick_bit(input logic [WORD_BITS-1:0] word,
		input logic [BIT_CTR_BITS-1:0] idx);
		if (LOWBIT_FIRST)
			return word[idx];
		else
			return word[WORD_BITS - 1 - int'(idx)];
	endfunction

	assign bit_next = bit_ctr + 1'b1;
	assign last_bit = (bit_ctr == BIT_CTR_BITS'(WORD_BITS - 1));
	assign start_word = pop ? head_word : word_reg;

	// loaded and shifting both count as busy
	assign busy = (state != ST_IDLE);

	// next state and pop
	always_comb begin
		state_next = state;
		pop = 1'b0;

		case (state)
			ST_IDLE: begin
				if (head_valid) begin
					pop = 1'b1;
					state_next = ST_LOADED;
				end
			end

			// wait for the next edge away from idle
			ST_LOADED: begin
				if (fall_tick)
					state_next = ST_SHIFT;
			end

			ST_SHIFT: begin
				if (fall_tick && last_bit) begin
					// chain the next word, else stop
					if (head_valid)
						pop = 1'b1;
					else
						state_next = ST_IDLE;
				end
			end

			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	// word register loads on every pop
	always_ff @(posedge in_clk) begin
		if (pop)
			word_reg <= start_word;
	end

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= ST_IDLE;
			bit_ctr <= '0;
			word_done <= 1'b0;
			out_clk <= SERIAL_CLK_INACTIVE;
			out_data <= SERIAL_DATA_INACTIVE;
		end else begin
			state <= state_next;
			word_done <= (state == ST_SHIFT) && fall_tick && last_bit;

			// sclk delayed by one cycle so it lines up with the data register
			out_clk <= (state_next == ST_SHIFT) ? sclk : SERIAL_CLK_INACTIVE;

			if (state_next != ST_SHIFT) begin
				out_data <= SERIAL_DATA_INACTIVE;
				bit_ctr <= '0;
			end else if (fall_tick) begin
				if (state == ST_SHIFT && !last_bit) begin
					// next bit of the current word
					bit_ctr <= bit_next;
					out_data <= pick_bit(word_reg, bit_next);
				end else begin
					// first bit of a fresh word
					bit_ctr <= '0;
					out_data <= pick_bit(start_word, '0);
				end
			end
		end
	end

endmodule

// File: verilog/frame_latch.sv
/*
 * frame latch generator
 *  - counts finished words modulo FRAME_WORDS
 *  - latch pulse of LATCH_CYCLES cycles per completed frame
 */

module frame_latch import serial_pkg::*; (
	input  logic in_clk,
	input  logic in_rst,

	input  logic word_done,
	output logic latch
);

	// words of the current frame
	logic [FRAME_CTR_BITS-1:0] word_ctr;
	// remaining latch cycles
	logic [LATCH_CTR_BITS-1:0] pulse_ctr;
	logic                      frame_end;

	assign frame_end = word_done && (word_ctr == FRAME_CTR_BITS'(FRAME_WORDS - 1));

	// high from the cycle after the last word done
	assign latch = (pulse_ctr != '0);

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			word_ctr <= '0;
		end else if (word_done) begin
			if (frame_end)
				word_ctr <= '0;
			else
				word_ctr <= word_ctr + 1'b1;
		end
	end

	// shifting goes on while the pulse runs
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			pulse_ctr <= '0;
		end else if (frame_end) begin
			pulse_ctr <= LATCH_CTR_BITS'(LATCH_CYCLES);
		end else if (pulse_ctr != '0) begin
			pulse_ctr <= pulse_ctr - 1'b1;
		end
	end

endmodule

// File: verilog/serial_link_top.sv
/*
 * serial link top level
 *  - word queue in front of the serialiser
 *  - serial clock divider
 *  - serialiser driving the shift register chain
 *  - frame latch pulse
 */

module serial_link_top import serial_pkg::*; (
	input  logic                 in_clk,
	input  logic                 in_rst,

	// host
	input  logic [WORD_BITS-1:0] in_word,
	input  logic                 in_write,
	output logic                 full,

	// shift register chain
	output logic                 out_clk,
	output logic                 out_data,
	output logic                 latch,

	output logic                 busy
);

	// queue to serialiser
	logic [WORD_BITS-1:0] head_word;
	logic                 head_valid;
	logic                 pop;

	// divider to serialiser
	logic sclk;
	logic fall_tick;

	// serialiser to latch
	logic word_done;

	word_queue word_queue_inst (
		.in_clk     (in_clk),
		.in_rst     (in_rst),
		.in_word    (in_word),
		.in_write   (in_write),
		.full       (full),
		.pop        (pop),
		.head_word  (head_word),
		.head_valid (head_valid)
	);

	serial_clock_gen serial_clock_gen_inst (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.sclk      (sclk),
		.fall_tick (fall_tick)
	);

	word_serializer word_serializer_inst (
		.in_clk     (in_clk),
		.in_rst     (in_rst),
		.head_word  (head_word),
		.head_valid (head_valid),
		.pop        (pop),
		.sclk       (sclk),
		.fall_tick  (fall_tick),
		.word_done  (word_done),
		.busy       (busy),
		.out_clk    (out_clk),
		.out_data   (out_data)
	);

	frame_latch frame_latch_inst (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.word_done (word_done),
		.latch     (latch)
	);

endmodule

// File: verification/tb_serial_link.sv
/*
 * testbench of the serial link
 *  - clock, reset and host stimulus
 *  - reference queue of accepted words, word assembly from the line
 *  - immediate assertions on levels, data, clock shape, chaining and latch
 *  - cycle watchdog
 */

module tb_serial_link import serial_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SINGLE_WORDS = 4;
	localparam int BURSTS = 2;
	localparam int BURST_LEN = QUEUE_DEPTH + 2;
	localparam int RANDOM_WRITES = 40;
	localparam int TOTAL_WRITES = SINGLE_WORDS + BURSTS * BURST_LEN + RANDOM_WRITES;
	localparam int WORD_CYCLES = WORD_BITS * 2 * CLK_DIV_HALF;
	localparam int CYCLE_LIMIT = 2 * TOTAL_WRITES * WORD_CYCLES + 2000;

	logic                 in_clk;
	logic                 in_rst;
	logic [WORD_BITS-1:0] in_word;
	logic                 in_write;
	logic                 full;
	logic                 out_clk;
	logic                 out_data;
	logic                 latch;
	logic                 busy;

	// accepted words not yet seen complete on the line
	logic [WORD_BITS-1:0] model_q [$];

	logic [WORD_BITS-1:0] asm_word;
	int                   bit_idx;
	int                   words_seen;
	longint               cyc;
	longint               last_rise;
	longint               latch_due;
	int                   phase_len;
	int                   latch_len;
	bit                   high_valid;
	bit                   chain_expected;
	// accepted words still waiting in the queue
	int                   unread;
	// last rising edge ended a word
	bit                   boundary;
	logic                 prev_clk;
	logic                 prev_data;
	logic                 prev_latch;
	logic                 prev_busy;
	int                   cycle_ctr;

	serial_link_top serial_link_top_inst (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.in_word  (in_word),
		.in_write (in_write),
		.full     (full),
		.out_clk  (out_clk),
		.out_data (out_data),
		.latch    (latch),
		.busy     (busy)
	);

	task automatic report_failure(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	initial begin
		in_clk = 1'b0;
		forever #5 in_clk = ~in_clk;
	end

	// watchdog
	always @(posedge in_clk) begin
		cycle_ctr <= cycle_ctr + 1;
		if (cycle_ctr >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$fatal(1, "watchdog expired");
		end
	end

	// one host write per call
	task automatic write_word(input logic [WORD_BITS-1:0] w);
		@(posedge in_clk);
		in_write <= 1'b1;
		in_word <= w;
		@(posedge in_clk);
		in_write <= 1'b0;
	endtask

	// writes on consecutive cycles, the tail is dropped by a full queue
	task automatic write_burst(input int len);
		for (int i = 0; i < len; i++) begin
			@(posedge in_clk);
			in_write <= 1'b1;
			in_word <= WORD_BITS'($urandom);
		end
		@(posedge in_clk);
		in_write <= 1'b0;
	endtask

	// line drained and latch pulse over
	task automatic wait_drained();
		while (model_q.size() != 0 || busy || latch)
			@(posedge in_clk);
	endtask

	// monitor, sampled away from the active edge
	always @(negedge in_clk) begin
		if (in_rst) begin
			assert (out_clk == SERIAL_CLK_INACTIVE && out_data == SERIAL_DATA_INACTIVE)
				else report_failure("serial lines not idle during reset");
			assert (!latch && !busy && !full)
				else report_failure("latch, busy or full high during reset");
		end else begin
			cyc++;
			// idle levels
			if (!busy) begin
				assert (out_clk == SERIAL_CLK_INACTIVE && out_data == SERIAL_DATA_INACTIVE)
					else report_failure("serial lines not idle while not busy");
			end

			// a word left the queue in the previous cycle
			if ((busy && !prev_busy) || (boundary && prev_clk && !out_clk))
				unread--;
			if (!busy || out_clk != prev_clk)
				boundary = 1'b0;
			// full one cycle after the last free slot is taken
			assert (full == (unread == QUEUE_DEPTH))
				else report_failure($sformatf("full is %0b with %0d unread words",
					full, unread));
			if (in_write && !full) begin
				model_q.push_back(in_word);
				unread++;
			end

			// data moves only with a falling clock
			if (busy && out_data != prev_data) begin
				assert (prev_clk == 1'b1 && out_clk == 1'b0)
					else report_failure("data changed away from a falling clock edge");
			end

			if (out_clk != prev_clk) begin
				if (out_clk) begin
					assert (phase_len == CLK_DIV_HALF)
						else report_failure("low phase of out_clk has wrong length");
					// regular spacing inside a word and across chained words
					if (bit_idx != 0 || chain_expected) begin
						assert (cyc - last_rise == 2 * CLK_DIV_HALF)
							else report_failure("gap between rising edges");
					end
					chain_expected = 1'b0;
					last_rise = cyc;
					high_valid = 1'b1;
					asm_word[bit_idx] = out_data;
					bit_idx++;
					if (bit_idx == WORD_BITS) begin
						assert (model_q.size() != 0)
							else report_failure("word on the line that was never accepted");
						assert (asm_word == model_q[0])
							else report_failure($sformatf("word %0d is %h, expected %h",
								words_seen, asm_word, model_q[0]));
						void'(model_q.pop_front());
						words_seen++;
						bit_idx = 0;
						boundary = 1'b1;
						if (words_seen % FRAME_WORDS == 0)
							latch_due = cyc + CLK_DIV_HALF + 1;
						chain_expected = (model_q.size() != 0);
					end
				end else if (high_valid) begin
					assert (phase_len == CLK_DIV_HALF)
						else report_failure("high phase of out_clk has wrong length");
				end
				phase_len = 1;
			end else begin
				phase_len++;
			end
			if (!busy)
				high_valid = 1'b0;
			if (chain_expected) begin
				assert (busy) else report_failure("busy dropped with words waiting");
			end

			// latch timing and width
			if (latch && !prev_latch) begin
				assert (cyc == latch_due)
					else report_failure("latch rose at the wrong cycle");
				latch_len = 0;
			end else begin
				assert (cyc != latch_due)
					else report_failure("latch missing after a completed frame");
			end
			if (latch)
				latch_len++;
			if (!latch && prev_latch) begin
				assert (latch_len == LATCH_CYCLES)
					else report_failure("latch pulse has wrong width");
			end
		end
		prev_clk = out_clk;
		prev_data = out_data;
		prev_latch = latch;
		prev_busy = busy;
	end

	initial begin
		int writes;

		in_rst = 1'b1;
		in_write = 1'b0;
		in_word = '0;
		cycle_ctr = 0;
		bit_idx = 0;
		words_seen = 0;
		cyc = 0;
		last_rise = 0;
		latch_due = -1;
		phase_len = 0;
		latch_len = 0;
		high_valid = 1'b0;
		chain_expected = 1'b0;
		unread = 0;
		boundary = 1'b0;
		prev_clk = SERIAL_CLK_INACTIVE;
		prev_data = SERIAL_DATA_INACTIVE;
		prev_latch = 1'b0;
		prev_busy = 1'b0;
		void'($urandom(32'he144));

		repeat (10) @(posedge in_clk);
		in_rst <= 1'b0;
		repeat (2) @(posedge in_clk);

		// single words with idle gaps
		for (int i = 0; i < SINGLE_WORDS; i++) begin
			write_word(WORD_BITS'($urandom));
			wait_drained();
			repeat (20) @(posedge in_clk);
		end

		// overfilling bursts
		for (int i = 0; i < BURSTS; i++) begin
			write_burst(BURST_LEN);
			wait_drained();
		end

		// sparse random writes, often chained
		writes = 0;
		while (writes < RANDOM_WRITES) begin
			@(posedge in_clk);
			if ($urandom % 32 == 0) begin
				in_write <= 1'b1;
				in_word <= WORD_BITS'($urandom);
				writes++;
			end else begin
				in_write <= 1'b0;
			end
		end
		@(posedge in_clk);
		in_write <= 1'b0;
		wait_drained();
		repeat (10) @(posedge in_clk);

		if (bit_idx == 0 && unread == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("partial word on the line or unread words left at the end of the run");
			$display("Testbench failed");
			$fatal(1, "run ended with an unfinished word");
		end
	end

endmodule

// File: project.f
verilog/serial_pkg.sv
verilog/word_queue.sv
verilog/serial_clock_gen.sv
verilog/word_serializer.sv
verilog/frame_latch.sv
verilog/serial_link_top.sv
verification/tb_serial_link.sv

// File: Makefile
# Verilator build and run of the serial link testbench

VERILATOR ?= verilator
TOP ?= tb_serial_link
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert
PASS_TEXT ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# simulator binary, rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
